/* src/exec_pkg.sv */
package exec_pkg;

  // rv32 fixes the data width
  localparam int XLEN = 32;
  localparam int TAG_W = 4;

  // intake queue, also the upstream's starting credit count
  localparam int ISSUE_DEPTH = 4;
  localparam int ISSUE_PTR_W = $clog2(ISSUE_DEPTH);
  localparam int ISSUE_CNT_W = $clog2(ISSUE_DEPTH + 1);

  // result queue and downstream buffer size
  localparam int RES_DEPTH = 4;
  localparam int RES_PTR_W = $clog2(RES_DEPTH);
  localparam int RES_CNT_W = $clog2(RES_DEPTH + 1);
  localparam int RES_CREDITS = 2;
  localparam int RES_CRD_W = $clog2(RES_CREDITS + 1);

  // alu codes keep the funct7[5],funct3 layout
  // branches fill the six unused codes
  typedef enum logic [3:0] {
    OP_ADD  = 4'b0000,
    OP_SLL  = 4'b0001,
    OP_SLT  = 4'b0010,
    OP_SLTU = 4'b0011,
    OP_XOR  = 4'b0100,
    OP_SRL  = 4'b0101,
    OP_OR   = 4'b0110,
    OP_AND  = 4'b0111,
    OP_SUB  = 4'b1000,
    OP_BEQ  = 4'b1001,
    OP_BNE  = 4'b1010,
    OP_BLT  = 4'b1011,
    OP_BGE  = 4'b1100,
    OP_SRA  = 4'b1101,
    OP_BLTU = 4'b1110,
    OP_BGEU = 4'b1111
  } alu_op_e;

  // packet from decode
  typedef struct packed {
    alu_op_e           op;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
  } issue_t;

  // packet to writeback
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   value;
    logic              taken;
  } result_t;

endpackage

/* src/issue_intake.sv */
`timescale 1ns/1ps

module issue_intake
  import exec_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  // upstream side, credit based
  input  logic    issue_valid_i,
  input  issue_t  issue_i,
  output logic    issue_credit_o,
  // towards the alu
  input  logic    accept_i,
  output logic    head_valid_o,
  output issue_t  head_o
);

  // packet storage
  issue_t                  mem [ISSUE_DEPTH];
  logic [ISSUE_PTR_W-1:0]  wr_ptr;
  logic [ISSUE_PTR_W-1:0]  rd_ptr;
  logic [ISSUE_CNT_W-1:0]  count;
  logic                    pop;

  // head is visible right after the write edge
  assign head_valid_o = (count != '0);
  assign head_o = mem[rd_ptr];
  assign pop = accept_i && head_valid_o;

  // sender only pushes while holding a credit, so never full here
  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      mem[wr_ptr] <= issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      issue_credit_o <= 1'b0;
    end else begin
      if (issue_valid_i) begin
        wr_ptr <= wr_ptr + ISSUE_PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ISSUE_PTR_W'(1);
      end
      // push and pop together leave count alone
      case ({issue_valid_i, pop})
        2'b10:   count <= count + ISSUE_CNT_W'(1);
        2'b01:   count <= count - ISSUE_CNT_W'(1);
        default: count <= count;
      endcase
      // one credit back per freed entry
      issue_credit_o <= pop;
    end
  end

endmodule

/* src/rv32_alu.sv */
`timescale 1ns/1ps

module rv32_alu
  import exec_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  issue_t   in_i,
  output logic     out_valid_o,
  output result_t  out_o
);

  // comparisons shared by slt and branches
  logic             equal;
  logic             less_u;
  logic             less_s;
  // value paths
  logic [XLEN-1:0]  sum;
  logic [XLEN-1:0]  diff;
  logic [4:0]       shamt;
  logic [XLEN-1:0]  sll;
  logic [XLEN-1:0]  srl;
  logic [XLEN-1:0]  sra;
  result_t          res_d;

  assign equal = (in_i.a == in_i.b);
  assign less_u = (in_i.a < in_i.b);
  assign less_s = ($signed(in_i.a) < $signed(in_i.b));

  assign sum = in_i.a + in_i.b;
  assign diff = in_i.a - in_i.b;

  // only the low five bits count as shift amount
  assign shamt = in_i.b[4:0];
  assign sll = in_i.a << shamt;
  assign srl = in_i.a >> shamt;
  // sign fill comes from the signed cast
  assign sra = $signed(in_i.a) >>> shamt;

  always_comb begin
    res_d.tag = in_i.tag;
    res_d.value = '0;
    res_d.taken = 1'b0;
    case (in_i.op)
      OP_ADD:  res_d.value = sum;
      OP_SUB:  res_d.value = diff;
      OP_SLL:  res_d.value = sll;
      OP_SRL:  res_d.value = srl;
      OP_SRA:  res_d.value = sra;
      // slt compares signed and sltu unsigned
      OP_SLT:  res_d.value = {{(XLEN-1){1'b0}}, less_s};
      OP_SLTU: res_d.value = {{(XLEN-1){1'b0}}, less_u};
      OP_XOR:  res_d.value = in_i.a ^ in_i.b;
      OP_OR:   res_d.value = in_i.a | in_i.b;
      OP_AND:  res_d.value = in_i.a & in_i.b;
      // branches report taken only and leave value at zero
      OP_BEQ:  res_d.taken = equal;
      OP_BNE:  res_d.taken = !equal;
      OP_BLT:  res_d.taken = less_s;
      OP_BGE:  res_d.taken = !less_s;
      OP_BLTU: res_d.taken = less_u;
      OP_BGEU: res_d.taken = !less_u;
    endcase
  end

  // result payload only moves on a captured packet
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      out_o <= res_d;
    end
  end

  // valid follows the capture by one stage
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= in_valid_i;
    end
  end

endmodule

/* src/result_queue.sv */
`timescale 1ns/1ps

module result_queue
  import exec_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  // from the alu stage
  input  logic     alu_valid_i,
  input  result_t  alu_res_i,
  output logic     accept_o,
  // downstream side, credit based
  input  logic     res_credit_i,
  output logic     res_valid_o,
  output result_t  res_o
);

  result_t                mem [RES_DEPTH];
  logic [RES_PTR_W-1:0]   wr_ptr;
  logic [RES_PTR_W-1:0]   rd_ptr;
  logic [RES_CNT_W-1:0]   count;
  logic [RES_CNT_W-1:0]   count_next;
  logic [RES_CNT_W:0]     occupancy_next;
  logic [RES_CRD_W-1:0]   credits;
  logic                   send;

  // oldest entry goes out whenever a credit is left
  assign send = (count != '0) && (credits != '0);
  assign res_valid_o = send;
  assign res_o = mem[rd_ptr];

  always_comb begin
    case ({alu_valid_i, send})
      2'b10:   count_next = count + RES_CNT_W'(1);
      2'b01:   count_next = count - RES_CNT_W'(1);
      default: count_next = count;
    endcase
  end

  // worst case, whatever we accept now sits in the alu next cycle
  assign occupancy_next = {1'b0, count_next} + (RES_CNT_W+1)'(accept_o);

  always_ff @(posedge clk_i) begin
    if (alu_valid_i) begin
      mem[wr_ptr] <= alu_res_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= RES_CRD_W'(RES_CREDITS);
      accept_o <= 1'b0;
    end else begin
      if (alu_valid_i) wr_ptr <= wr_ptr + RES_PTR_W'(1);
      if (send) rd_ptr <= rd_ptr + RES_PTR_W'(1);
      count <= count_next;
      // spend one per send, regain one per returned pulse
      case ({send, res_credit_i})
        2'b10:   credits <= credits - RES_CRD_W'(1);
        2'b01:   credits <= credits + RES_CRD_W'(1);
        default: credits <= credits;
      endcase
      // stored plus in flight must stay below depth
      accept_o <= (occupancy_next < (RES_CNT_W+1)'(RES_DEPTH));
    end
  end

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
  import exec_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  // issue from decode
  input  logic     issue_valid_i,
  input  issue_t   issue_i,
  output logic     issue_credit_o,
  // results to writeback
  input  logic     res_credit_i,
  output logic     res_valid_o,
  output result_t  res_o
);

  // intake head into the alu
  logic     head_valid;
  issue_t   head;
  // result queue room, pops the intake
  logic     accept;
  // alu stage output
  logic     alu_valid;
  result_t  alu_res;

  issue_intake i_intake (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_i        (issue_i),
    .issue_credit_o (issue_credit_o),
    .accept_i       (accept),
    .head_valid_o   (head_valid),
    .head_o         (head)
  );

  // alu captures only on a pop
  rv32_alu i_alu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (head_valid && accept),
    .in_i        (head),
    .out_valid_o (alu_valid),
    .out_o       (alu_res)
  );

  result_queue i_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .alu_valid_i  (alu_valid),
    .alu_res_i    (alu_res),
    .accept_o     (accept),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o)
  );

endmodule

/* bench/exec_unit_props.sv */
`timescale 1ns/1ps

module exec_unit_props
  import exec_pkg::*;
(
  input logic  clk_i,
  input logic  rst_i,
  input logic  issue_valid_i,
  input logic  pop_i,
  input logic  issue_credit_i,
  input logic  alu_valid_i,
  input logic  accept_i,
  input logic  res_valid_i,
  input logic  res_credit_i
);

  // downstream credits as writeback sees them
  int credits;
  // entries sitting in the intake
  int held;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits <= RES_CREDITS;
      held <= 0;
    end else begin
      credits <= credits - int'(res_valid_i) + int'(res_credit_i);
      held <= held + int'(issue_valid_i) - int'(pop_i);
    end
  end

  // a send spends a credit that must exist
  send_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i |-> credits > 0)
    else $error("res_valid_o high with no downstream credit left");

  intake_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    held <= ISSUE_DEPTH)
    else $error("intake holds more than ISSUE_DEPTH entries");

  // all quiet right after a reset edge
  quiet_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !(res_valid_i || alu_valid_i || accept_i || issue_credit_i))
    else $error("valid or credit signal high in the cycle after reset");

endmodule

bind exec_unit exec_unit_props i_props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .issue_valid_i  (issue_valid_i),
  .pop_i          (head_valid && accept),
  .issue_credit_i (issue_credit_o),
  .alu_valid_i    (alu_valid),
  .accept_i       (accept),
  .res_valid_i    (res_valid_o),
  .res_credit_i   (res_credit_i)
);

/* bench/exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb
  import exec_pkg::*;
();

  localparam int STALL_LIMIT = 300;
  localparam int MAX_PACKETS = 1024;

  logic     clk_i;
  logic     rst_i;
  logic     issue_valid_i;
  issue_t   issue_i;
  logic     issue_credit_o;
  logic     res_credit_i = 1'b0;
  logic     res_valid_o;
  result_t  res_o;

  // model results by issue number, read back in arrival order
  result_t           expected [MAX_PACKETS];
  // operands near the sign boundary and all ones
  logic [XLEN-1:0]   corner [4] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h0};
  logic [TAG_W-1:0]  next_tag = '0;
  int  sent = 0;
  int  received = 0;
  // downstream credits handed back so far
  int  returned = 0;
  int  credit_pulses = 0;
  bit  hold_credits = 1'b0;
  int  result_errors = 0;
  int  run_errors = 0;

  exec_unit i_exec_unit (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // expected result from the rv32 rules
  function automatic result_t predict(input issue_t p);
    result_t     r;
    logic [4:0]  s;
    logic        lt_u;
    logic        lt_s;
    s = p.b[4:0];
    lt_u = (p.a < p.b);
    // signed order is unsigned order with both sign bits flipped
    lt_s = ((p.a ^ 32'h8000_0000) < (p.b ^ 32'h8000_0000));
    r.tag = p.tag;
    r.value = '0;
    r.taken = 1'b0;
    case (p.op)
      OP_ADD:  r.value = p.a + p.b;
      OP_SUB:  r.value = p.a - p.b;
      OP_SLL:  r.value = p.a << s;
      OP_SRL:  r.value = p.a >> s;
      // logical shift, then fill the vacated top bits with the sign
      OP_SRA:  r.value = (p.a >> s) | (p.a[XLEN-1] ? ~({XLEN{1'b1}} >> s) : '0);
      OP_SLT:  r.value = XLEN'(lt_s);
      OP_SLTU: r.value = XLEN'(lt_u);
      OP_XOR:  r.value = p.a ^ p.b;
      OP_OR:   r.value = p.a | p.b;
      OP_AND:  r.value = p.a & p.b;
      OP_BEQ:  r.taken = (p.a == p.b);
      OP_BNE:  r.taken = (p.a != p.b);
      OP_BLT:  r.taken = lt_s;
      OP_BGE:  r.taken = !lt_s;
      OP_BLTU: r.taken = lt_u;
      OP_BGEU: r.taken = !lt_u;
    endcase
    return r;
  endfunction

  function automatic logic [XLEN-1:0] pick_operand();
    if ($urandom_range(0, 2) == 0) begin
      return corner[$urandom_range(0, 3)];
    end
    return $urandom();
  endfunction

  // upstream credits, start at depth, one back per pulse
  function automatic int credits_left();
    return ISSUE_DEPTH - sent + credit_pulses;
  endfunction

  // one rising edge of upstream traffic, random gaps
  task automatic drive_cycle();
    issue_t p;
    @(posedge clk_i);
    if (credits_left() > 0 && $urandom_range(0, 3) != 0) begin
      p.op = alu_op_e'($urandom_range(0, 15));
      p.tag = next_tag;
      p.a = pick_operand();
      // equal operands, or ones differing only in the sign bit
      case ($urandom_range(0, 5))
        0:       p.b = p.a;
        1:       p.b = p.a ^ 32'h8000_0000;
        default: p.b = pick_operand();
      endcase
      issue_valid_i <= 1'b1;
      issue_i <= p;
      expected[sent % MAX_PACKETS] = predict(p);
      next_tag++;
      sent++;
    end else begin
      issue_valid_i <= 1'b0;
    end
  endtask

  task automatic send_packets(input int n);
    int target;
    int stall;
    target = sent + n;
    stall = 0;
    while (sent < target && stall < STALL_LIMIT) begin
      drive_cycle();
      stall = (credits_left() > 0) ? 0 : stall + 1;
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    if (sent < target) begin
      $display("timeout: issue credits stopped coming back");
      run_errors++;
    end
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while ((received < sent || returned < received) && cycles < STALL_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (received < sent || returned < received) begin
      $display("timeout: %s did not drain", what);
      run_errors++;
    end
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got.tag !== exp.tag) begin
      $display("error res_o.tag got %h expected %h", got.tag, exp.tag);
      result_errors++;
    end
    if (got.value !== exp.value) begin
      $display("error res_o.value got %h expected %h", got.value, exp.value);
      result_errors++;
    end
    if (got.taken !== exp.taken) begin
      $display("error res_o.taken got %h expected %h", got.taken, exp.taken);
      result_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      run_errors++;
    end
  endtask

  // sampled on the falling edge, inputs only move on the rising one
  always @(negedge clk_i) begin
    if (!rst_i && issue_credit_o) begin
      credit_pulses++;
    end
    if (!rst_i && res_valid_o) begin
      if (received >= sent) begin
        $display("a result arrived that was never issued");
        result_errors++;
      end else begin
        check_result(res_o, expected[received % MAX_PACKETS]);
      end
      received++;
    end
  end

  // writeback hands credits back after random delays
  always @(posedge clk_i) begin
    if (!rst_i && !hold_credits && returned < received && $urandom_range(0, 2) == 0) begin
      res_credit_i <= 1'b1;
      returned++;
    end else begin
      res_credit_i <= 1'b0;
    end
  end

  initial begin
    int received_mark;
    int pulses_mark;
    void'($urandom(32'h3728012d));
    rst_i = 1'b1;
    issue_valid_i = 1'b0;
    issue_i = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    // random mix, credits flowing both ways
    send_packets(300);
    wait_drained("random traffic");
    // writeback stops returning credits
    @(negedge clk_i);
    hold_credits = 1'b1;
    received_mark = received;
    repeat (80) drive_cycle();
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    pulses_mark = credit_pulses;
    repeat (20) @(posedge clk_i);
    check_count("results while credits withheld", received - received_mark, RES_CREDITS);
    check_count("issue_credit_o pulses during stall", credit_pulses - pulses_mark, 0);
    @(negedge clk_i);
    hold_credits = 1'b0;
    send_packets(100);
    wait_drained("traffic after credits resumed");
    repeat (4) @(posedge clk_i);
    check_count("results received", received, sent);
    check_count("issue_credit_o pulses", credit_pulses, sent);
    $display("result errors %0d, run errors %0d", result_errors, run_errors);
    if (result_errors == 0 && run_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/exec_pkg.sv
src/issue_intake.sv
src/rv32_alu.sv
src/result_queue.sv
src/exec_unit.sv
bench/exec_unit_props.sv
bench/exec_unit_tb.sv

/* Makefile */
# verilator flow for the execute unit, override any variable on the command line

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides, the simulator's exit code alone does not
sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
